/* common/simd_pkg.sv */
//########################################
// Shared types for the vector issue model
// src1_u is fixed at DEF_VLEN bits
// is_opvx selects which src1 member holds data
//########################################

package simd_pkg;

    localparam int DEF_VLEN = 128;   // Default vector length in bits
    localparam int SCALAR_W = 64;    // Scalar operand width
    localparam int STAGE_W  = 6;     // Width of an execute-stage count

    // Vector operations known to the issue logic
    typedef enum logic [4:0] {
        VADD,
        VAND,
        VMUL,
        VMULH,
        VMULHU,
        VWMUL,
        VMACC,
        VMADD,
        VNMSAC,
        VSMUL,
        VREDSUM,
        VREDMAX,
        VREDOR,
        VDIV,
        VDIVU,
        VREM,
        VREMU
    } simd_instr_e;

    // Only SIMD instructions take a writeback slot
    typedef enum logic {
        UNIT_SIMD,
        UNIT_OTHER
    } unit_e;

    typedef enum logic [1:0] {
        SEW_8,
        SEW_16,
        SEW_32,
        SEW_64
    } sew_e;

    // Latency classes of the execution unit
    typedef enum logic [2:0] {
        CLS_SIMPLE,
        CLS_MUL,
        CLS_MADD,
        CLS_RED,
        CLS_DIV
    } lat_class_e;

    // Scalar form of the first source, rs1 in the low half
    typedef struct packed {
        logic [DEF_VLEN-SCALAR_W-1:0] pad;
        logic [SCALAR_W-1:0]          rs1;
    } src1_scl_t;

    // First source word, either vs1 or the scalar rs1
    typedef union packed {
        logic [DEF_VLEN-1:0] vec;
        src1_scl_t           scl;
    } src1_u;

    // Divide and remainder share the iterative unit
    function automatic logic is_div_op(simd_instr_e op);
        return op inside {VDIV, VDIVU, VREM, VREMU};
    endfunction

endpackage

/* common/simd_issue_if.sv */
//########################################
// Issue bundle from the top to the blocks
// All fields are driven by the top level
//########################################

`timescale 1ns/1ps

interface simd_issue_if #(
    parameter int VLEN = simd_pkg::DEF_VLEN
);
    import simd_pkg::*;

    logic                     valid;
    unit_e                    unit;
    simd_instr_e              instr;
    logic                     is_opvx;   // First source is the scalar rs1
    sew_e                     sew;
    logic [$clog2(VLEN/8):0]  vl;
    logic [VLEN-1:0]          vs2;
    src1_u                    src1;

    modport decoder (input instr, sew, vl);
    modport reuse   (input valid, instr, is_opvx, vs2, src1);
    modport score   (input valid, unit);

endinterface

/* rtl/simd_class_decoder.sv */
//########################################
// Latency class and execute-stage count
// Assumes vl never exceeds VLEN/8
// Purely combinational
//########################################

`timescale 1ns/1ps

module simd_class_decoder #(
    parameter int VLEN       = simd_pkg::DEF_VLEN,
    parameter int DIV_STAGES = 32
) (
    simd_issue_if.decoder                iss,
    input  logic                         reuse_hit_i,
    output simd_pkg::lat_class_e         class_o,
    output logic [simd_pkg::STAGE_W-1:0] stages_o
);
    import simd_pkg::*;

    localparam int VL_W = $clog2(VLEN / 8) + 1;

    logic [STAGE_W-1:0] vl_log2;   // ceil(log2(vl)), reduction tree depth

    always_comb begin
        case (iss.instr)
            VADD, VAND:                   class_o = CLS_SIMPLE;
            VMUL, VMULH, VMULHU, VWMUL:   class_o = CLS_MUL;
            VMACC, VMADD, VNMSAC, VSMUL:  class_o = CLS_MADD;
            VREDSUM, VREDMAX, VREDOR:     class_o = CLS_RED;
            VDIV, VDIVU, VREM, VREMU:     class_o = CLS_DIV;
            default:                      class_o = CLS_SIMPLE;
        endcase
    end

    // Smallest k with 2^k >= vl
    always_comb begin
        vl_log2 = '0;
        for (int i = 0; i < VL_W; i++) begin
            if ((32'd1 << i) < 32'(iss.vl)) begin
                vl_log2 = STAGE_W'(i + 1);
            end
        end
    end

    always_comb begin
        case (class_o)
            CLS_MUL:  stages_o = (iss.sew == SEW_64) ? STAGE_W'(3) : STAGE_W'(2);
            CLS_MADD: stages_o = (iss.sew == SEW_64) ? STAGE_W'(4) : STAGE_W'(3);
            CLS_RED:  stages_o = vl_log2 + STAGE_W'(2);
            CLS_DIV:  begin
                // Result already known from the partner operation
                stages_o = reuse_hit_i ? STAGE_W'(1) : STAGE_W'(DIV_STAGES);
            end
            default:  stages_o = STAGE_W'(1);
        endcase
    end

endmodule

/* score_board/simd_div_reuse.sv */
//########################################
// Remembers operands of the last divide
// hit_o is combinational on the inputs
// Stored copy updates one edge after accept
//########################################

`timescale 1ns/1ps

module simd_div_reuse #(
    parameter int VLEN = simd_pkg::DEF_VLEN
) (
    input  logic        clk_i,
    input  logic        rstn_i,
    simd_issue_if.reuse iss,
    input  logic        accept_i,
    output logic        hit_o
);
    import simd_pkg::*;

    logic            stored_q;     // A divide has been seen since reset
    simd_instr_e     instr_q;
    logic            opvx_q;
    logic [VLEN-1:0] vs2_q;
    src1_u           src1_q;
    logic            store;
    logic            op_match;
    logic            src1_match;

    assign store = accept_i && is_div_op(iss.instr);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            stored_q <= 1'b0;
        end else if (store) begin
            stored_q <= 1'b1;
        end
    end

    // Operand copy, only meaningful once stored_q is set
    always_ff @(posedge clk_i) begin
        if (store) begin
            instr_q <= iss.instr;
            opvx_q  <= iss.is_opvx;
            vs2_q   <= iss.vs2;
            src1_q  <= iss.src1;
        end
    end

    // Same operation or its partner of equal signedness
    always_comb begin
        case (instr_q)
            VDIV, VREM:   op_match = iss.instr inside {VDIV, VREM};
            VDIVU, VREMU: op_match = iss.instr inside {VDIVU, VREMU};
            default:      op_match = 1'b0;
        endcase
    end

    assign src1_match = opvx_q ? (src1_q.scl.rs1 == iss.src1.scl.rs1)
                               : (src1_q.vec == iss.src1.vec);

    assign hit_o = iss.valid && is_div_op(iss.instr) && stored_q &&
                   (opvx_q == iss.is_opvx) && op_match &&
                   (vs2_q == iss.vs2) && src1_match;

endmodule

/* score_board/simd_score_board.sv */
//########################################
// Writeback port reservation per latency
// Flush clears short pipes, divides go on
// Stage counts above MAX_STAGES never retire
// unless they belong to a full divide
//########################################

`timescale 1ns/1ps

module simd_score_board #(
    parameter int VLEN       = simd_pkg::DEF_VLEN,
    parameter int DIV_STAGES = 32
) (
    input  logic                         clk_i,
    input  logic                         rstn_i,
    input  logic                         flush_i,
    simd_issue_if.score                  iss,
    input  simd_pkg::lat_class_e         class_i,
    input  logic [simd_pkg::STAGE_W-1:0] stages_i,
    output logic                         accept_o,
    output logic                         stall_o,
    output logic                         wb_valid_o
);
    import simd_pkg::*;

    localparam int MAX_STAGES = $clog2(VLEN / 8) + 2;

    logic                  simd_req;    // SIMD instruction on the issue port
    logic                  div_long;    // Divide that runs the full iterative unit
    logic [MAX_STAGES:1]   short_out;   // Last slot of each short pipe
    logic [MAX_STAGES:1]   short_hit;   // Port clash found in each short pipe
    logic [DIV_STAGES-1:0] div_q;
    logic                  div_hit;
    logic                  div_busy;
    logic                  wb_q;

    assign simd_req = iss.valid && (iss.unit == UNIT_SIMD);
    assign div_long = (class_i == CLS_DIV) && (stages_i > STAGE_W'(1));

    // One shift register per latency, slot j holds an entry j edges old
    for (genvar L = 1; L <= MAX_STAGES; L++) begin : g_pipe
        logic [L-1:0] sr_q;
        logic         load;
        logic         hit;

        assign load = accept_o && !div_long && (stages_i == STAGE_W'(L));

        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                sr_q <= '0;
            end else if (flush_i) begin
                sr_q <= '0;
            end else begin
                sr_q <= (sr_q << 1) | L'(load);
            end
        end

        // Entry in slot j retires L-j-1 edges before a new N-stage instruction
        always_comb begin
            hit = 1'b0;
            for (int j = 0; j < L; j++) begin
                if (sr_q[j] && (int'(stages_i) == L - j - 1)) begin
                    hit = 1'b1;
                end
            end
        end

        assign short_hit[L] = hit;
        assign short_out[L] = sr_q[L-1];
    end

    // Divide pipe, never flushed once a divide has started
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            div_q <= '0;
        end else begin
            div_q <= {div_q[DIV_STAGES-2:0], accept_o && div_long};
        end
    end

    always_comb begin
        div_hit = 1'b0;
        for (int j = 0; j < DIV_STAGES; j++) begin
            if (div_q[j] && (int'(stages_i) == DIV_STAGES - j - 1)) begin
                div_hit = 1'b1;
            end
        end
    end

    assign div_busy = |div_q;   // Single iterative divider

    assign stall_o  = simd_req && ((|short_hit) || div_hit || (div_long && div_busy));
    assign accept_o = simd_req && !stall_o && !flush_i;

    // Output flop adds the final cycle of every latency
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wb_q <= 1'b0;
        end else begin
            wb_q <= ((|short_out) && !flush_i) || div_q[DIV_STAGES-1];
        end
    end

    assign wb_valid_o = wb_q;

endmodule

/* rtl/simd_issue_top.sv */
//########################################
// Issue-side timing of the vector unit
// vs1_i is DEF_VLEN wide, fixed by src1_u
// Source holds its instruction while stalled
//########################################

`timescale 1ns/1ps

module simd_issue_top #(
    parameter int VLEN       = simd_pkg::DEF_VLEN,
    parameter int DIV_STAGES = 32
) (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          flush_i,
    input  logic                          valid_i,
    input  simd_pkg::unit_e               unit_i,
    input  simd_pkg::simd_instr_e         instr_i,
    input  logic                          is_opvx_i,
    input  simd_pkg::sew_e                sew_i,
    input  logic [$clog2(VLEN/8):0]       vl_i,
    input  logic [VLEN-1:0]               vs2_i,
    input  logic [simd_pkg::DEF_VLEN-1:0] vs1_i,
    input  logic [simd_pkg::SCALAR_W-1:0] rs1_i,
    output logic                          stall_o,
    output logic                          wb_valid_o,
    output logic [simd_pkg::STAGE_W-1:0]  exe_stages_o
);
    import simd_pkg::*;

    lat_class_e         op_class;
    logic [STAGE_W-1:0] stages;
    logic               reuse_hit;
    logic               accept;
    src1_u              src1;

    simd_issue_if #(.VLEN(VLEN)) iss ();

    // Scalar form keeps rs1 in the low half
    always_comb begin
        if (is_opvx_i) begin
            src1.scl.pad = '0;
            src1.scl.rs1 = rs1_i;
        end else begin
            src1.vec = vs1_i;
        end
    end

    assign iss.valid   = valid_i;
    assign iss.unit    = unit_i;
    assign iss.instr   = instr_i;
    assign iss.is_opvx = is_opvx_i;
    assign iss.sew     = sew_i;
    assign iss.vl      = vl_i;
    assign iss.vs2     = vs2_i;
    assign iss.src1    = src1;

    simd_class_decoder #(.VLEN(VLEN), .DIV_STAGES(DIV_STAGES)) u_decoder (
        .iss         (iss),
        .reuse_hit_i (reuse_hit),
        .class_o     (op_class),
        .stages_o    (stages)
    );

    simd_div_reuse #(.VLEN(VLEN)) u_div_reuse (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .iss      (iss),
        .accept_i (accept),
        .hit_o    (reuse_hit)
    );

    simd_score_board #(.VLEN(VLEN), .DIV_STAGES(DIV_STAGES)) u_score_board (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .flush_i    (flush_i),
        .iss        (iss),
        .class_i    (op_class),
        .stages_i   (stages),
        .accept_o   (accept),
        .stall_o    (stall_o),
        .wb_valid_o (wb_valid_o)
    );

    assign exe_stages_o = stages;

endmodule

/* testbench/tb_simd_issue.sv */
//########################################
// Random and directed issue stream
// Model tracks writebacks by edge number
// vl is kept in 1..VLEN/8
//########################################

`timescale 1ns/1ps

module tb_simd_issue;
    import simd_pkg::*;

    localparam int VLEN           = DEF_VLEN;
    localparam int DIV_STAGES     = 32;
    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 8;
    localparam int NUM_INSTR      = 300;
    localparam int DIRECTED_N     = 6;
    localparam int WIN            = 64;   // Model window longer than a divide
    localparam int VL_W           = $clog2(VLEN / 8) + 1;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * (DIV_STAGES + 10) + RESET_CYCLES +
                                    DIV_STAGES + 20;
    localparam logic [31:0] VS2_SALT = 32'h3C5A_9617;
    localparam logic [31:0] VS1_SALT = 32'h71E2_04BD;

    logic                  clk_i = 1'b0;
    logic                  rstn_i;
    logic                  flush_i;
    logic                  valid_i;
    unit_e                 unit_i;
    simd_instr_e           instr_i;
    logic                  is_opvx_i;
    sew_e                  sew_i;
    logic [VL_W-1:0]       vl_i;
    logic [VLEN-1:0]       vs2_i;
    logic [DEF_VLEN-1:0]   vs1_i;
    logic [SCALAR_W-1:0]   rs1_i;
    logic                  stall_o;
    logic                  wb_valid_o;
    logic [STAGE_W-1:0]    exe_stages_o;

    logic [31:0]           lfsr_q = 32'd80515;
    int                    edge_cnt;
    logic                  pend_short [WIN];   // Flushable writebacks by edge
    logic                  pend_div   [WIN];
    int                    div_pending;

    // Last divide accepted by the model
    logic                  ref_stored;
    int                    ref_fam;
    logic                  ref_opvx;
    logic [VLEN-1:0]       ref_vs2;
    logic [DEF_VLEN-1:0]   ref_vs1;
    logic [SCALAR_W-1:0]   ref_rs1;

    int cov_hit_vec;
    int cov_hit_scl;
    int cov_port_stall;
    int cov_div_stall;
    int cov_flush_div;

    simd_issue_top #(.VLEN(VLEN), .DIV_STAGES(DIV_STAGES)) u_dut (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .flush_i      (flush_i),
        .valid_i      (valid_i),
        .unit_i       (unit_i),
        .instr_i      (instr_i),
        .is_opvx_i    (is_opvx_i),
        .sew_i        (sew_i),
        .vl_i         (vl_i),
        .vs2_i        (vs2_i),
        .vs1_i        (vs1_i),
        .rs1_i        (rs1_i),
        .stall_o      (stall_o),
        .wb_valid_o   (wb_valid_o),
        .exe_stages_o (exe_stages_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic fail_run();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual)
        else begin
            $display("[ERROR] %s at edge %0d: expected %0d, actual %0d",
                     name, edge_cnt, expected, actual);
            fail_run();
        end
    endtask

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            val    = {val[30:0], lfsr_q[0]};
        end
    endtask

    // Two-entry operand pools so that repeats are common
    function automatic logic [VLEN-1:0] pool_vec(input logic sel, input logic [31:0] salt);
        logic [31:0] w;
        w = salt ^ (sel ? 32'h5A5A_0F0F : 32'h1234_ABCD);
        return {w, ~w, w + 32'd1, w ^ 32'hFFFF_0000};
    endfunction

    function automatic logic [SCALAR_W-1:0] pool_scl(input logic sel);
        logic [31:0] w;
        w = sel ? 32'hC0DE_7A11 : 32'h0BAD_F00D;
        return {~w, w};
    endfunction

    // 1 for signed divide or remainder, 2 for unsigned, 0 otherwise
    function automatic int divide_family(input simd_instr_e op);
        case (op)
            VDIV, VREM:   return 1;
            VDIVU, VREMU: return 2;
            default:      return 0;
        endcase
    endfunction

    function automatic int ref_stages(input simd_instr_e op, input sew_e sew, input int vl,
                                      input logic hit);
        int k;
        k = 0;
        case (op)
            VMUL, VMULH, VMULHU, VWMUL:  return (sew == SEW_64) ? 3 : 2;
            VMACC, VMADD, VNMSAC, VSMUL: return (sew == SEW_64) ? 4 : 3;
            VREDSUM, VREDMAX, VREDOR: begin
                while ((1 << k) < vl) begin
                    k++;
                end
                return k + 2;   // Tree depth plus two
            end
            VDIV, VDIVU, VREM, VREMU:    return hit ? 1 : DIV_STAGES;
            default:                     return 1;
        endcase
    endfunction

    function automatic simd_instr_e op_from_code(input logic [2:0] cat, input logic [1:0] sub);
        simd_instr_e simple_ops [4];
        simd_instr_e mul_ops    [4];
        simd_instr_e madd_ops   [4];
        simd_instr_e red_ops    [4];
        simd_instr_e div_ops    [4];
        simple_ops = '{VADD, VAND, VADD, VAND};
        mul_ops    = '{VMUL, VMULH, VMULHU, VWMUL};
        madd_ops   = '{VMACC, VMADD, VNMSAC, VSMUL};
        red_ops    = '{VREDSUM, VREDMAX, VREDOR, VREDSUM};
        div_ops    = '{VDIV, VDIVU, VREM, VREMU};
        case (cat)
            3'd0:       return simple_ops[sub];
            3'd1:       return mul_ops[sub];
            3'd2, 3'd4: return madd_ops[sub];
            3'd3:       return red_ops[sub];
            default:    return div_ops[sub];   // Three codes out of eight
        endcase
    endfunction

    task automatic load_directed(input int step);
        valid_i   = 1'b1;
        unit_i    = UNIT_SIMD;
        sew_i     = SEW_32;
        vl_i      = VL_W'(VLEN / 8);
        is_opvx_i = 1'b0;
        vs2_i     = pool_vec(1'b0, VS2_SALT);
        vs1_i     = pool_vec(1'b0, VS1_SALT);
        rs1_i     = pool_scl(1'b1);
        case (step)
            0: instr_i = VDIV;
            1: instr_i = VREM;       // Vector partner of step 0
            2: begin
                instr_i = VMUL;
                sew_i   = SEW_64;
            end
            3: begin
                instr_i   = VDIVU;   // Waits for the busy divider
                is_opvx_i = 1'b1;
            end
            4: begin
                instr_i   = VREMU;   // Scalar partner with a different vs1
                is_opvx_i = 1'b1;
                vs1_i     = pool_vec(1'b1, VS1_SALT);
            end
            default: instr_i = VREDSUM;
        endcase
    endtask

    task automatic load_random();
        logic [31:0] c;
        logic [31:0] r;
        draw_bits(3, r);
        valid_i = (r[2:0] != 3'd0);
        draw_bits(4, r);
        unit_i = (r[3:0] == 4'd0) ? UNIT_OTHER : UNIT_SIMD;
        draw_bits(3, c);
        draw_bits(2, r);
        instr_i = op_from_code(c[2:0], r[1:0]);
        draw_bits(2, r);
        sew_i = sew_e'(r[1:0]);
        draw_bits(4, r);
        vl_i = VL_W'(int'(r[3:0]) + 1);
        draw_bits(1, r);
        is_opvx_i = r[0];
        draw_bits(2, r);
        vs2_i = pool_vec(&r[1:0], VS2_SALT);   // Entry 0 three times out of four
        draw_bits(2, r);
        vs1_i = pool_vec(&r[1:0], VS1_SALT);
        draw_bits(2, r);
        rs1_i = pool_scl(&r[1:0]);
    endtask

    // Writeback due at the edge just passed
    task automatic check_writeback();
        int idx;
        idx = edge_cnt % WIN;
        check_value("writeback", int'(pend_short[idx] || pend_div[idx]), int'(wb_valid_o));
        if (pend_div[idx]) begin
            div_pending--;
        end
        pend_short[idx] = 1'b0;
        pend_div[idx]   = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        int          exp_n;
        int          fam;
        int          slot;
        int          drop;
        int          issued;
        int          step;
        logic        exp_hit;
        logic        exp_stall;
        logic        slot_taken;
        logic        long_div;
        logic        hold;
        logic        accept;

        rstn_i    = 1'b0;
        flush_i   = 1'b1;   // Keeps the reset probe from issuing
        valid_i   = 1'b1;
        unit_i    = UNIT_SIMD;
        instr_i   = VDIV;   // Full divide probes the divide pipe after reset
        is_opvx_i = 1'b0;
        sew_i     = SEW_8;
        vl_i      = VL_W'(1);
        vs2_i     = '0;
        vs1_i     = '0;
        rs1_i     = '0;
        for (int i = 0; i < WIN; i++) begin
            pend_short[i] = 1'b0;
            pend_div[i]   = 1'b0;
        end
        edge_cnt    = 0;
        div_pending = 0;
        ref_stored  = 1'b0;
        issued      = 0;
        step        = 0;
        hold        = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk_i);
        #2 rstn_i = 1'b1;
        @(negedge clk_i);
        check_value("reset stall", 0, int'(stall_o));
        check_value("reset writeback", 0, int'(wb_valid_o));

        while (issued < NUM_INSTR) begin
            @(posedge clk_i);
            edge_cnt++;
            #2;
            if (!hold) begin
                if (step < DIRECTED_N) begin
                    load_directed(step);
                    step++;
                end else begin
                    load_random();
                end
            end
            draw_bits(4, r);
            flush_i = (r[3:0] == 4'd0);

            @(negedge clk_i);
            check_writeback();

            fam     = divide_family(instr_i);
            exp_hit = valid_i && (fam != 0) && ref_stored && (fam == ref_fam) &&
                      (is_opvx_i == ref_opvx) && (vs2_i == ref_vs2) &&
                      (is_opvx_i ? (rs1_i == ref_rs1) : (vs1_i == ref_vs1));
            exp_n   = ref_stages(instr_i, sew_i, int'(vl_i), exp_hit);
            check_value("stage count", exp_n, int'(exe_stages_o));

            // Accept would happen at the next edge
            slot       = (edge_cnt + 1 + exp_n) % WIN;
            slot_taken = pend_short[slot] || pend_div[slot];
            long_div   = (fam != 0) && !exp_hit;
            exp_stall  = valid_i && (unit_i == UNIT_SIMD) &&
                         (slot_taken || (long_div && (div_pending > 0)));
            check_value("stall", int'(exp_stall), int'(stall_o));
            if (exp_stall && slot_taken) cov_port_stall++;
            if (exp_stall && long_div && (div_pending > 0)) cov_div_stall++;

            if (flush_i) begin
                drop = 0;
                for (int i = 0; i < WIN; i++) begin
                    if (pend_short[i]) drop++;
                    pend_short[i] = 1'b0;
                end
                if ((drop > 0) && (div_pending > 0)) cov_flush_div++;
            end

            accept = valid_i && (unit_i == UNIT_SIMD) && !exp_stall && !flush_i;
            if (accept) begin
                if (long_div) begin
                    pend_div[slot] = 1'b1;
                    div_pending++;
                end else begin
                    pend_short[slot] = 1'b1;
                end
                if (fam != 0) begin
                    ref_stored = 1'b1;
                    ref_fam    = fam;
                    ref_opvx   = is_opvx_i;
                    ref_vs2    = vs2_i;
                    ref_vs1    = vs1_i;
                    ref_rs1    = rs1_i;
                end
                if (exp_hit && is_opvx_i) cov_hit_scl++;
                if (exp_hit && !is_opvx_i) cov_hit_vec++;
            end

            // Other-unit instructions pass without a slot
            hold = valid_i && !accept && (unit_i == UNIT_SIMD);
            if (valid_i && !hold) issued++;
        end

        // Let every divide in flight retire
        repeat (DIV_STAGES + 4) begin
            @(posedge clk_i);
            edge_cnt++;
            #2;
            valid_i = 1'b0;
            flush_i = 1'b0;
            @(negedge clk_i);
            check_writeback();
        end

        if ((cov_hit_vec > 0) && (cov_hit_scl > 0) && (cov_port_stall > 0) &&
            (cov_div_stall > 0) && (cov_flush_div > 0)) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Stimulus missed a case: reuse %0d/%0d, stalls %0d/%0d, flush %0d",
                     cov_hit_vec, cov_hit_scl, cov_port_stall, cov_div_stall, cov_flush_div);
            fail_run();
        end
    end

    // Each instruction may wait out one full divide
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("Watchdog expired after %0d cycles, issue did not finish", TIMEOUT_CYCLES);
        fail_run();
    end

endmodule

/* compile.f */
common/simd_pkg.sv
common/simd_issue_if.sv
rtl/simd_class_decoder.sv
score_board/simd_div_reuse.sv
score_board/simd_score_board.sv
rtl/simd_issue_top.sv
testbench/tb_simd_issue.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_simd_issue
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^Test OK$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
